// ==== source/tmr_pkg.sv ====
`default_nettype none

package tmr_pkg;

  // Core result widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned TAG_W  = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // Bit i belongs to core i
  typedef logic [2:0] core_mask_t;

  // Redundancy modes of the group
  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } tmr_mode_e;

  localparam tmr_mode_e RESET_MODE = NON_TMR;

  // One unload saves exactly as many words as the store holds
  localparam int unsigned STATE_WORDS = 8;
  typedef logic [$clog2(STATE_WORDS+1)-1:0] fill_t;

  localparam int unsigned CNT_W = 8;
  typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== source/tmr_voter.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t           a_i,
  input  payload_t           b_i,
  input  payload_t           c_i,
  output payload_t           vote_o,
  output tmr_pkg::core_mask_t err_o,
  output logic               none_agree_o
);

  logic ab_eq;
  logic ac_eq;
  logic bc_eq;

  assign ab_eq = (a_i == b_i);
  assign ac_eq = (a_i == c_i);
  assign bc_eq = (b_i == c_i);

  // Cores 1 and 2 only outvote core 0 when they agree with each other
  assign vote_o = bc_eq ? b_i : a_i;

  assign none_agree_o = !(ab_eq || ac_eq || bc_eq);

  assign err_o[0] = (a_i != vote_o);
  assign err_o[1] = (b_i != vote_o);
  assign err_o[2] = (c_i != vote_o);

endmodule

`default_nettype wire

// ==== source/tmr_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_cfg_regs (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic tmr_enable_q_i,
  input  logic tmr_enable_qe_i,
  input  logic delay_resynch_q_i,
  input  logic delay_resynch_qe_i,
  input  logic setback_q_i,
  input  logic setback_qe_i,
  input  logic reload_setback_q_i,
  input  logic reload_setback_qe_i,
  input  logic force_resynch_q_i,
  input  logic force_resynch_qe_i,
  input  logic force_consume_i,
  output logic enable_o,
  output logic delay_resynch_o,
  output logic setback_en_o,
  output logic reload_setback_o,
  output logic force_pending_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_o         <= 1'b0;
      delay_resynch_o  <= 1'b0;
      setback_en_o     <= 1'b0;
      reload_setback_o <= 1'b0;
      force_pending_o  <= 1'b0;
    end else begin
      if (tmr_enable_qe_i) begin
        enable_o <= tmr_enable_q_i;
      end
      if (delay_resynch_qe_i) begin
        delay_resynch_o <= delay_resynch_q_i;
      end
      if (setback_qe_i) begin
        setback_en_o <= setback_q_i;
      end
      if (reload_setback_qe_i) begin
        reload_setback_o <= reload_setback_q_i;
      end
      // A new strobe beats the consume pulse of the same cycle
      if (force_resynch_qe_i) begin
        force_pending_o <= force_resynch_q_i;
      end else if (force_consume_i) begin
        force_pending_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/tmr_mismatch_cnt.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_mismatch_cnt (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tmr_pkg::core_mask_t incr_i,
  input  logic                clear_i,
  output tmr_pkg::cnt_t       cnt0_o,
  output tmr_pkg::cnt_t       cnt1_o,
  output tmr_pkg::cnt_t       cnt2_o
);

  import tmr_pkg::*;

  cnt_t cnt_q [3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clear_i) begin
          cnt_q[i] <= '0;
        end else if (incr_i[i] && (cnt_q[i] != {CNT_W{1'b1}})) begin
          // Hold at all ones once saturated
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end
      end
    end
  end

  assign cnt0_o = cnt_q[0];
  assign cnt1_o = cnt_q[1];
  assign cnt2_o = cnt_q[2];

endmodule

`default_nettype wire

// ==== source/tmr_state_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_state_store (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  tmr_pkg::data_t push_data_i,
  input  logic           pop_i,
  output tmr_pkg::data_t top_data_o,
  output tmr_pkg::fill_t fill_o,
  output logic           empty_o,
  output logic           full_o,
  output logic           last_pop_o
);

  import tmr_pkg::*;

  data_t mem_q [STATE_WORDS];
  fill_t fill_q;
  logic [$clog2(STATE_WORDS)-1:0] wr_idx;
  logic [$clog2(STATE_WORDS)-1:0] rd_idx;

  // Next free slot is at fill, the top word sits just below it
  assign wr_idx = fill_q[$clog2(STATE_WORDS)-1:0];
  assign rd_idx = wr_idx - 1'b1;

  assign empty_o    = (fill_q == '0);
  assign full_o     = (fill_q == fill_t'(STATE_WORDS));
  assign last_pop_o = (fill_q == fill_t'(1)) && pop_i;
  assign fill_o     = fill_q;
  assign top_data_o = empty_o ? '0 : mem_q[rd_idx];

  always_ff @(posedge clk_i) begin
    if (push_i && !full_o) begin
      mem_q[wr_idx] <= push_data_i;
    end
  end

  // Push has priority when both strobes arrive together
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= '0;
    end else if (push_i) begin
      if (!full_o) begin
        fill_q <= fill_q + fill_t'(1);
      end
    end else if (pop_i && !empty_o) begin
      fill_q <= fill_q - fill_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== source/tmr_ctrl_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_ctrl_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic                delay_resynch_i,
  input  logic                setback_en_i,
  input  logic                reload_setback_i,
  input  logic                force_pending_i,
  input  logic                single_mismatch_i,
  input  logic                failure_i,
  input  tmr_pkg::core_mask_t tmr_error_i,
  input  logic                store_full_i,
  input  logic                store_empty_i,
  input  logic                store_last_pop_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  output tmr_pkg::tmr_mode_e  mode_o,
  output logic                setback_o,
  output logic                sw_resynch_req_o,
  output logic                sw_synch_req_o,
  output logic                grp_in_independent_o,
  output tmr_pkg::core_mask_t incr_mask_o,
  output logic                force_consume_o
);

  import tmr_pkg::*;

  tmr_mode_e mode_d, mode_q;
  logic      setback_d, setback_q;

  always_comb begin
    mode_d           = mode_q;
    setback_d        = 1'b0;
    incr_mask_o      = '0;
    force_consume_o  = 1'b0;
    sw_resynch_req_o = 1'b0;

    case (mode_q)
      TMR_RUN: begin
        incr_mask_o = tmr_error_i;
        // Forced resync is consumed even when it is held off
        if (force_pending_i) begin
          force_consume_o = 1'b1;
          if (!delay_resynch_i) begin
            mode_d = TMR_UNLOAD;
          end
        end
        if (single_mismatch_i && !delay_resynch_i) begin
          mode_d = TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        sw_resynch_req_o = 1'b1;
        if (store_full_i) begin
          mode_d    = TMR_RELOAD;
          setback_d = setback_en_i;
        end
      end
      TMR_RELOAD: begin
        if (store_empty_i) begin
          mode_d = TMR_RUN;
        end else if ((single_mismatch_i || failure_i) && setback_en_i &&
                     reload_setback_i && !store_last_pop_i) begin
          // Restart the reload if the cores diverge again
          setback_d = 1'b1;
        end
      end
      default: begin
      end
    endcase

    // Entry and exit of redundant operation
    if (!fetch_en_i) begin
      mode_d = enable_i ? TMR_RUN : NON_TMR;
    end
    if (mode_q == TMR_RUN && !enable_i) begin
      mode_d = NON_TMR;
    end
    if (mode_q == NON_TMR && cores_synch_i && enable_i) begin
      mode_d = TMR_RELOAD;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= RESET_MODE;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o               = mode_q;
  assign setback_o            = setback_q;
  assign grp_in_independent_o = (mode_q == NON_TMR);
  assign sw_synch_req_o       = enable_i && (mode_q == NON_TMR);

endmodule

`default_nettype wire

// ==== source/tmr_group.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_group (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tmr_pkg::data_t      core0_data_i,
  input  tmr_pkg::data_t      core1_data_i,
  input  tmr_pkg::data_t      core2_data_i,
  input  tmr_pkg::tag_t       core0_tag_i,
  input  tmr_pkg::tag_t       core1_tag_i,
  input  tmr_pkg::tag_t       core2_tag_i,
  input  logic                tmr_enable_q_i,
  input  logic                tmr_enable_qe_i,
  input  logic                delay_resynch_q_i,
  input  logic                delay_resynch_qe_i,
  input  logic                setback_q_i,
  input  logic                setback_qe_i,
  input  logic                reload_setback_q_i,
  input  logic                reload_setback_qe_i,
  input  logic                force_resynch_q_i,
  input  logic                force_resynch_qe_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  input  logic                store_push_i,
  input  logic                store_pop_i,
  input  logic                cnt_clear_i,
  output tmr_pkg::data_t      voted_data_o,
  output tmr_pkg::tag_t       voted_tag_o,
  output tmr_pkg::core_mask_t tmr_error_o,
  output tmr_pkg::tmr_mode_e  mode_o,
  output logic                setback_o,
  output logic                sw_resynch_req_o,
  output logic                sw_synch_req_o,
  output logic                grp_in_independent_o,
  output tmr_pkg::cnt_t       cnt0_o,
  output tmr_pkg::cnt_t       cnt1_o,
  output tmr_pkg::cnt_t       cnt2_o,
  output tmr_pkg::data_t      reload_data_o,
  output tmr_pkg::fill_t      store_fill_o
);

  import tmr_pkg::*;

  core_mask_t data_err, tag_err, tmr_error, incr_mask;
  logic       data_none, tag_none;
  logic       single_mismatch, failure;
  logic       enable, delay_resynch, setback_en, reload_setback, force_pending;
  logic       force_consume;
  logic       store_empty, store_full, store_last_pop;

  tmr_voter #(.payload_t(data_t)) u_data_voter (
    .a_i          (core0_data_i),
    .b_i          (core1_data_i),
    .c_i          (core2_data_i),
    .vote_o       (voted_data_o),
    .err_o        (data_err),
    .none_agree_o (data_none)
  );

  tmr_voter #(.payload_t(tag_t)) u_tag_voter (
    .a_i          (core0_tag_i),
    .b_i          (core1_tag_i),
    .c_i          (core2_tag_i),
    .vote_o       (voted_tag_o),
    .err_o        (tag_err),
    .none_agree_o (tag_none)
  );

  // A core is wrong if either field disagrees with the majority
  assign tmr_error       = data_err | tag_err;
  assign tmr_error_o     = tmr_error;
  assign single_mismatch = |tmr_error;
  assign failure         = data_none || tag_none;

  tmr_cfg_regs u_cfg_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .tmr_enable_q_i      (tmr_enable_q_i),
    .tmr_enable_qe_i     (tmr_enable_qe_i),
    .delay_resynch_q_i   (delay_resynch_q_i),
    .delay_resynch_qe_i  (delay_resynch_qe_i),
    .setback_q_i         (setback_q_i),
    .setback_qe_i        (setback_qe_i),
    .reload_setback_q_i  (reload_setback_q_i),
    .reload_setback_qe_i (reload_setback_qe_i),
    .force_resynch_q_i   (force_resynch_q_i),
    .force_resynch_qe_i  (force_resynch_qe_i),
    .force_consume_i     (force_consume),
    .enable_o            (enable),
    .delay_resynch_o     (delay_resynch),
    .setback_en_o        (setback_en),
    .reload_setback_o    (reload_setback),
    .force_pending_o     (force_pending)
  );

  tmr_mismatch_cnt u_mismatch_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .incr_i  (incr_mask),
    .clear_i (cnt_clear_i),
    .cnt0_o  (cnt0_o),
    .cnt1_o  (cnt1_o),
    .cnt2_o  (cnt2_o)
  );

  tmr_state_store u_state_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (store_push_i),
    .push_data_i (voted_data_o),
    .pop_i       (store_pop_i),
    .top_data_o  (reload_data_o),
    .fill_o      (store_fill_o),
    .empty_o     (store_empty),
    .full_o      (store_full),
    .last_pop_o  (store_last_pop)
  );

  tmr_ctrl_fsm u_ctrl_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .enable_i             (enable),
    .delay_resynch_i      (delay_resynch),
    .setback_en_i         (setback_en),
    .reload_setback_i     (reload_setback),
    .force_pending_i      (force_pending),
    .single_mismatch_i    (single_mismatch),
    .failure_i            (failure),
    .tmr_error_i          (tmr_error),
    .store_full_i         (store_full),
    .store_empty_i        (store_empty),
    .store_last_pop_i     (store_last_pop),
    .fetch_en_i           (fetch_en_i),
    .cores_synch_i        (cores_synch_i),
    .mode_o               (mode_o),
    .setback_o            (setback_o),
    .sw_resynch_req_o     (sw_resynch_req_o),
    .sw_synch_req_o       (sw_synch_req_o),
    .grp_in_independent_o (grp_in_independent_o),
    .incr_mask_o          (incr_mask),
    .force_consume_o      (force_consume)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset covers two full periods and lifts on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tmr_group_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmr_group_assertions (
  input logic               clk_i,
  input logic               rst_ni,
  input tmr_pkg::tmr_mode_e mode_i,
  input logic               sw_resynch_req_i,
  input logic               grp_in_independent_i,
  input tmr_pkg::fill_t     store_fill_i
);

  import tmr_pkg::*;

  // Resync is only requested while the cores unload
  resynch_only_in_unload: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    sw_resynch_req_i |-> (mode_i == TMR_UNLOAD)
  ) else $error("sw_resynch_req_o high outside TMR_UNLOAD");

  independent_flag_matches_mode: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    grp_in_independent_i == (mode_i == NON_TMR)
  ) else $error("grp_in_independent_o disagrees with mode_o");

  // Store never holds more than one unload
  fill_within_depth: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    store_fill_i <= fill_t'(STATE_WORDS)
  ) else $error("store_fill_o above STATE_WORDS");

endmodule

bind tmr_group tmr_group_assertions u_assertions (
  .clk_i                (clk_i),
  .rst_ni               (rst_ni),
  .mode_i               (mode_o),
  .sw_resynch_req_i     (sw_resynch_req_o),
  .grp_in_independent_i (grp_in_independent_o),
  .store_fill_i         (store_fill_o)
);

`default_nettype wire

// ==== tests/tb_tmr_group.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_tmr_group;

  import tmr_pkg::*;

  logic clk_i;
  logic rst_ni;

  // Stimulus registers
  data_t      core0_data, core1_data, core2_data;
  tag_t       core0_tag, core1_tag, core2_tag;
  logic [9:0] cfg_drv;
  logic [4:0] ctl_drv;

  // DUT outputs
  data_t      voted_data, reload_data;
  tag_t       voted_tag;
  core_mask_t tmr_error;
  tmr_mode_e  mode;
  logic       setback, sw_resynch_req, sw_synch_req, grp_in_independent;
  cnt_t       cnt0, cnt1, cnt2;
  fill_t      store_fill;

  // One trace line
  int         rep;
  data_t      t_d0, t_d1, t_d2;
  tag_t       t_t0, t_t1, t_t2;
  logic [9:0] t_cfg;
  logic [4:0] t_ctl;
  logic [1:0] e_mode;
  data_t      e_vdata, e_rdata;
  tag_t       e_vtag;
  core_mask_t e_err;
  cnt_t       e_c0, e_c1, e_c2;
  fill_t      e_fill;
  logic       e_setback;

  // Enable bit as the configuration register holds it after the last edge
  logic  exp_enable = 1'b0;

  int    fd;
  int    n;
  int    line_no = 0;
  int    lines_checked = 0;
  int    cycle_limit = 0;
  int    cycle_cnt = 0;
  string line_s;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  tmr_group u_tmr_group (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .core0_data_i         (core0_data),
    .core1_data_i         (core1_data),
    .core2_data_i         (core2_data),
    .core0_tag_i          (core0_tag),
    .core1_tag_i          (core1_tag),
    .core2_tag_i          (core2_tag),
    .tmr_enable_q_i       (cfg_drv[1]),
    .tmr_enable_qe_i      (cfg_drv[0]),
    .delay_resynch_q_i    (cfg_drv[3]),
    .delay_resynch_qe_i   (cfg_drv[2]),
    .setback_q_i          (cfg_drv[5]),
    .setback_qe_i         (cfg_drv[4]),
    .reload_setback_q_i   (cfg_drv[7]),
    .reload_setback_qe_i  (cfg_drv[6]),
    .force_resynch_q_i    (cfg_drv[9]),
    .force_resynch_qe_i   (cfg_drv[8]),
    .fetch_en_i           (ctl_drv[4]),
    .cores_synch_i        (ctl_drv[3]),
    .store_push_i         (ctl_drv[2]),
    .store_pop_i          (ctl_drv[1]),
    .cnt_clear_i          (ctl_drv[0]),
    .voted_data_o         (voted_data),
    .voted_tag_o          (voted_tag),
    .tmr_error_o          (tmr_error),
    .mode_o               (mode),
    .setback_o            (setback),
    .sw_resynch_req_o     (sw_resynch_req),
    .sw_synch_req_o       (sw_synch_req),
    .grp_in_independent_o (grp_in_independent),
    .cnt0_o               (cnt0),
    .cnt1_o               (cnt1),
    .cnt2_o               (cnt2),
    .reload_data_o        (reload_data),
    .store_fill_o         (store_fill)
  );

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mode(input string name, input tmr_mode_e got, input tmr_mode_e exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t got, input core_mask_t exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_fill(input string name, input fill_t got, input fill_t exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s (trace line %0d): got %h, expected %h", name, line_no, got, exp);
      fail_run();
    end
  endtask

  function automatic int open_trace();
    return $fopen("tests/tmr_group_trace.txt", "r");
  endfunction

  function automatic bit is_data_line(input string s);
    return (s.len() > 1) && (s.getc(0) != "#");
  endfunction

  // Sums the repeat column so the timeout scales with the trace
  task automatic count_trace_cycles(output int total);
    int    cfd;
    int    r;
    string s;
    total = 0;
    cfd = open_trace();
    if (cfd == 0) begin
      $display("Could not open the trace file tests/tmr_group_trace.txt");
      fail_run();
    end else begin
      while ($fgets(s, cfd) != 0) begin
        if (is_data_line(s) && ($sscanf(s, "%d", r) == 1)) begin
          total += r;
        end
      end
      $fclose(cfd);
    end
  endtask

  task automatic apply_inputs();
    core0_data <= t_d0;
    core1_data <= t_d1;
    core2_data <= t_d2;
    core0_tag  <= t_t0;
    core1_tag  <= t_t1;
    core2_tag  <= t_t2;
    cfg_drv    <= t_cfg;
    ctl_drv    <= t_ctl;
  endtask

  task automatic check_outputs();
    check_mode("mode_o", mode, tmr_mode_e'(e_mode));
    check_word("voted_data_o", voted_data, e_vdata);
    check_tag("voted_tag_o", voted_tag, e_vtag);
    check_mask("tmr_error_o", tmr_error, e_err);
    check_count("cnt0_o", cnt0, e_c0);
    check_count("cnt1_o", cnt1, e_c1);
    check_count("cnt2_o", cnt2, e_c2);
    check_fill("store_fill_o", store_fill, e_fill);
    check_bit("setback_o", setback, e_setback);
    check_word("reload_data_o", reload_data, e_rdata);
    check_bit("sw_resynch_req_o", sw_resynch_req,
              tmr_mode_e'(e_mode) == TMR_UNLOAD);
    check_bit("sw_synch_req_o", sw_synch_req,
              exp_enable && (tmr_mode_e'(e_mode) == NON_TMR));
    check_bit("grp_in_independent_o", grp_in_independent,
              tmr_mode_e'(e_mode) == NON_TMR);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the trace did not finish", cycle_cnt);
      fail_run();
    end
  end

  initial begin
    core0_data <= '0;
    core1_data <= '0;
    core2_data <= '0;
    core0_tag  <= '0;
    core1_tag  <= '0;
    core2_tag  <= '0;
    cfg_drv    <= '0;
    ctl_drv    <= '0;
    count_trace_cycles(n);
    cycle_limit = 2 * n + 20;
    fd = open_trace();
    if (fd == 0) begin
      $display("Could not open the trace file tests/tmr_group_trace.txt");
      fail_run();
    end else begin
      wait (rst_ni === 1'b1);
      while ($fgets(line_s, fd) != 0) begin
        line_no++;
        if (is_data_line(line_s)) begin
          n = $sscanf(line_s, "%d %h %h %h %h %h %h %h %b %h %h %h %h %h %h %h %h %h %h",
                      rep, t_d0, t_d1, t_d2, t_t0, t_t1, t_t2, t_cfg, t_ctl,
                      e_mode, e_vdata, e_vtag, e_err, e_c0, e_c1, e_c2,
                      e_fill, e_setback, e_rdata);
          if (n != 19) begin
            $display("Trace line %0d is malformed, read %0d fields", line_no, n);
            fail_run();
          end else begin
            // Hold the line for rep cycles, check in the last one
            repeat (rep) begin
              @(posedge clk_i);
              // Enable register loads the strobe pair driven up to this edge
              if (cfg_drv[0]) begin
                exp_enable = cfg_drv[1];
              end
              apply_inputs();
            end
            @(negedge clk_i);
            check_outputs();
            lines_checked++;
          end
        end
      end
      $fclose(fd);
      if (lines_checked == 0) begin
        $display("The trace file held no cycles to check");
        fail_run();
      end else begin
        $display("All checks passed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tmr_group_trace.txt ====
# rep d0 d1 d2 t0 t1 t2 cfg ctl | mode vdata vtag err cnt0 cnt1 cnt2 fill setback rdata
# cfg {fr_q,fr_qe,rs_q,rs_qe,sb_q,sb_qe,dr_q,dr_qe,en_q,en_qe}, ctl {fetch,synch,push,pop,clear}
# Expected values are those seen in the (last) cycle the line is applied
1 11111111 11111111 11111111 1 1 1 000 00000 0 11111111 1 0 00 00 00 0 0 00000000
1 AAAA0000 BBBB0000 AAAA0000 2 2 2 000 00000 0 AAAA0000 2 2 00 00 00 0 0 00000000
1 CCCCCCCC CCCCCCCC CCCCCCCC 3 3 5 000 00000 0 CCCCCCCC 3 4 00 00 00 0 0 00000000
1 00000001 00000002 00000003 1 1 1 003 00000 0 00000001 1 6 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 000 00000 0 55555555 5 0 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 001 00000 1 55555555 5 0 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 000 10000 1 55555555 5 0 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 003 10000 0 55555555 5 0 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 000 11000 0 55555555 5 0 00 00 00 0 0 00000000
1 55555555 55555555 55555555 5 5 5 000 10000 3 55555555 5 0 00 00 00 0 0 00000000
1 77777777 77777777 77777770 7 7 7 000 10000 1 77777777 7 4 00 00 00 0 0 00000000
1 10000001 10000001 10000001 0 0 0 030 10100 2 10000001 0 0 00 00 01 0 0 00000000
1 10000002 10000002 10000002 0 0 0 000 10100 2 10000002 0 0 00 00 01 1 0 10000001
1 10000003 10000003 10000003 0 0 0 000 10100 2 10000003 0 0 00 00 01 2 0 10000002
1 10000004 10000004 10000004 0 0 0 000 10100 2 10000004 0 0 00 00 01 3 0 10000003
1 10000005 10000005 10000005 0 0 0 000 10100 2 10000005 0 0 00 00 01 4 0 10000004
1 10000006 10000006 10000006 0 0 0 000 10100 2 10000006 0 0 00 00 01 5 0 10000005
1 10000007 10000007 10000007 0 0 0 000 10100 2 10000007 0 0 00 00 01 6 0 10000006
1 10000008 10000008 10000008 0 0 0 000 10100 2 10000008 0 0 00 00 01 7 0 10000007
1 20000000 20000000 20000000 0 0 0 000 10000 2 20000000 0 0 00 00 01 8 0 10000008
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 8 1 10000008
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 7 0 10000007
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 6 0 10000006
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 5 0 10000005
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 4 0 10000004
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 3 0 10000003
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 2 0 10000002
1 20000000 20000000 20000000 0 0 0 000 10010 3 20000000 0 0 00 00 01 1 0 10000001
1 20000000 20000000 20000000 0 0 0 000 10000 3 20000000 0 0 00 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 00C 10000 1 20000000 0 0 00 00 01 0 0 00000000
1 0000DEAD 0000BEEF 0000BEEF 0 0 0 000 10000 1 0000BEEF 0 1 00 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 304 10000 1 20000000 0 0 01 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 10000 1 20000000 0 0 01 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 00000 2 20000000 0 0 01 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 00C 10000 1 20000000 0 0 01 00 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 10000 1 20000000 0 0 01 00 01 0 0 00000000
300 0000F00D 0000F00E 0000F00D 0 0 0 000 10000 1 0000F00D 0 2 01 FF 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 10000 1 20000000 0 0 01 FF 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 10001 1 20000000 0 0 01 FF 01 0 0 00000000
1 20000000 20000000 20000000 0 0 0 000 10000 1 20000000 0 0 00 00 00 0 0 00000000

// ==== sources.f ====
source/tmr_pkg.sv
source/tmr_voter.sv
source/tmr_cfg_regs.sv
source/tmr_mismatch_cnt.sv
source/tmr_state_store.sv
source/tmr_ctrl_fsm.sv
source/tmr_group.sv
tests/tb_clk_gen.sv
tests/tmr_group_assertions.sv
tests/tb_tmr_group.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_tmr_group -f sources.f -Mdir obj_dir
./obj_dir/Vtb_tmr_group 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
